// ==== logic/anticParams.svh ====
// ############################
// Display list constants
// ############################

`ifndef ANTIC_PARAMS_SVH
`define ANTIC_PARAMS_SVH

// Number of bytes held between the fetcher and the interpreter
// The buffer index math needs a power of two here (2, 4 or 8)
`define DL_FIFO_DEPTH 4

// The pointer counts inside a 1 KB block and the bits above stay fixed
`define DL_WRAP_BITS 10

// Background line code for the colour chip
`define AN_BG_COLOR 3'b000

// Mode field of an instruction byte
`define OP_MODE_LSB 0
`define OP_MODE_MSB 3

// Mode values kept in this design
`define OP_MODE_BLANK 4'h0
`define OP_MODE_JUMP 4'h1

// Set on a jump means wait for vertical blank after the jump
`define OP_JVB_BIT 6

// Blank line count field, the instruction gives this value plus one lines
`define OP_COUNT_LSB 4
`define OP_COUNT_MSB 6

`endif

// ==== logic/anticPkg.sv ====
// ############################
// Display list types
// ############################

package anticPkg;

  // Address on the display list RAM port
  typedef logic [15:0] dlAddrT;

  // One display list byte as read from RAM and held in the FIFO
  typedef logic [7:0] dlByteT;

  // Line code sent to the colour chip
  typedef logic [2:0] anCodeT;

  // The fetcher either has no read in flight or waits for one reply
  typedef enum logic {
    fetchIdle,
    fetchWait
  } fetchStateT;

  // Jump instructions walk through the low byte, the high byte and the
  // execute cycle before they return to decode
  typedef enum logic [2:0] {
    interpDecode,
    interpBlank,
    interpJumpLow,
    interpJumpHigh,
    interpJumpExec,
    interpWaitVblank
  } interpStateT;

endpackage

// ==== logic/dlFetcher.sv ====
// ############################
// Display list fetcher
// ############################

`timescale 1ns/1ps
`include "anticParams.svh"

module dlFetcher (
  input  logic                                    Fphi0,
  input  logic                                    RST,
  input  logic                                    dlistLoad,
  input  anticPkg::dlAddrT                        dlistStart,
  input  logic                                    dlistJump,
  input  anticPkg::dlAddrT                        jumpAddr,
  output anticPkg::dlAddrT                        memAddr,
  output logic                                    memRead,
  input  anticPkg::dlByteT                        memData,
  input  logic                                    memValid,
  input  logic [$clog2(`DL_FIFO_DEPTH + 1) - 1:0] fifoCount,
  output logic                                    push,
  output anticPkg::dlByteT                        pushData,
  output logic                                    flush
);
  import anticPkg::*;

  localparam int countWidth = $clog2(`DL_FIFO_DEPTH + 1);

  fetchStateT state;
  dlAddrT     dlPtr;
  dlAddrT     reloadAddr;
  logic       reload;
  logic       stale;
  logic       slotFree;

  // A CPU load and a jump both restart the list walk
  // The CPU load takes priority if both arrive together
  assign reload     = dlistLoad | dlistJump;
  assign reloadAddr = dlistLoad ? dlistStart : jumpAddr;

  // Only checked with no read in flight, so the FIFO count alone tells
  // whether the next reply will fit
  assign slotFree = (fifoCount < countWidth'(`DL_FIFO_DEPTH));

  // The RAM sees the pointer as it stands while memRead is high
  assign memAddr = dlPtr;

  // Bytes fetched before a restart belong to the old list and go away
  assign flush = reload;

  // A reply is forwarded in its own cycle unless it was asked for before a
  // restart, or a restart lands on the same cycle
  assign push     = memValid && (state == fetchWait) && !stale && !reload;
  assign pushData = memData;

  always_ff @(posedge Fphi0) begin
    if (RST) begin
      state   <= fetchIdle;
      memRead <= 1'b0;
      stale   <= 1'b0;
      dlPtr   <= '0;
    end else begin
      memRead <= 1'b0;

      // Pointer steps once per read and wraps inside its 1 KB block
      if (reload) begin
        dlPtr <= reloadAddr;
      end else if (memRead) begin
        dlPtr <= {dlPtr[15:`DL_WRAP_BITS], dlPtr[`DL_WRAP_BITS - 1:0] + 1'b1};
      end

      case (state)
        fetchIdle: begin
          // Hold off for one cycle on a restart so the flush settles first
          if (!reload && slotFree) begin
            memRead <= 1'b1;
            state   <= fetchWait;
          end
        end

        fetchWait: begin
          if (memValid) begin
            state <= fetchIdle;
            stale <= 1'b0;
          end else if (reload) begin
            // Reply still on its way, drop it when it shows up
            stale <= 1'b1;
          end
        end

        default: begin
          state <= fetchIdle;
        end
      endcase
    end
  end

endmodule

// ==== logic/dlBuffer.sv ====
// ############################
// Display list byte FIFO
// ############################

`timescale 1ns/1ps
`include "anticParams.svh"

module dlBuffer (
  input  logic                                    Fphi0,
  input  logic                                    RST,
  input  logic                                    push,
  input  anticPkg::dlByteT                        pushData,
  input  logic                                    pop,
  output anticPkg::dlByteT                        popData,
  input  logic                                    flush,
  output logic                                    empty,
  output logic [$clog2(`DL_FIFO_DEPTH + 1) - 1:0] count
);
  import anticPkg::*;

  localparam int depth      = `DL_FIFO_DEPTH;
  localparam int idxWidth   = $clog2(depth);
  localparam int countWidth = $clog2(depth + 1);

  dlByteT              mem [depth];
  logic [idxWidth-1:0] rdIdx;
  logic [idxWidth-1:0] wrIdx;
  logic                doPush;
  logic                doPop;

  assign empty = (count == '0);

  // Flush beats both push and pop in the same cycle
  assign doPop  = pop && !empty && !flush;
  assign doPush = push && !flush && ((count < countWidth'(depth)) || doPop);

  // Head entry falls through so the interpreter can look before it pops
  assign popData = mem[rdIdx];

  always_ff @(posedge Fphi0) begin
    if (RST || flush) begin
      rdIdx <= '0;
      wrIdx <= '0;
      count <= '0;
    end else begin
      // Indices wrap on their own since the depth is a power of two
      if (doPush) begin
        wrIdx <= wrIdx + 1'b1;
      end
      if (doPop) begin
        rdIdx <= rdIdx + 1'b1;
      end

      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage only, the indices decide what is valid
  always_ff @(posedge Fphi0) begin
    if (doPush) begin
      mem[wrIdx] <= pushData;
    end
  end

endmodule

// ==== logic/dlInterpreter.sv ====
// ############################
// Display list interpreter
// ############################

`timescale 1ns/1ps
`include "anticParams.svh"

module dlInterpreter (
  input  logic             Fphi0,
  input  logic             RST,
  input  logic             vblank,
  input  logic             empty,
  input  anticPkg::dlByteT popData,
  output logic             pop,
  output anticPkg::anCodeT AN,
  output logic             anValid,
  output logic             dlistJump,
  output anticPkg::dlAddrT jumpAddr,
  output logic             dlistEnd
);
  import anticPkg::*;

  localparam int lineCntWidth = `OP_COUNT_MSB - `OP_COUNT_LSB + 1;

  interpStateT             state;
  logic [lineCntWidth-1:0] lineCnt;
  logic [lineCntWidth-1:0] opCount;
  logic [3:0]              opMode;
  logic                    popEnable;
  logic                    blankStart;
  logic                    jumpStart;
  logic                    lineSend;
  logic                    jvbFlag;

  // Fields of the byte at the head of the FIFO
  assign opMode  = popData[`OP_MODE_MSB:`OP_MODE_LSB];
  assign opCount = popData[`OP_COUNT_MSB:`OP_COUNT_LSB];

  // Bytes are taken in decode and while gathering the jump address
  // In every other state the FIFO is left alone and backs up
  assign popEnable = (state inside {interpDecode, interpJumpLow, interpJumpHigh});
  assign pop       = popEnable && !empty;

  // A blank opcode sends its first line straight away
  assign blankStart = (state == interpDecode) && !empty && (opMode == `OP_MODE_BLANK);
  assign jumpStart  = (state == interpDecode) && !empty && (opMode == `OP_MODE_JUMP);
  assign lineSend   = blankStart || (state == interpBlank);

  always_ff @(posedge Fphi0) begin
    if (RST) begin
      state     <= interpDecode;
      lineCnt   <= '0;
      anValid   <= 1'b0;
      dlistJump <= 1'b0;
      dlistEnd  <= 1'b0;
    end else begin
      // Lines and jumps are single cycle events unless set again below
      anValid   <= lineSend;
      dlistJump <= 1'b0;

      case (state)
        interpDecode: begin
          if (blankStart) begin
            // Remaining lines after the first one
            lineCnt <= opCount;
            if (opCount != '0) begin
              state <= interpBlank;
            end
          end else if (jumpStart) begin
            state <= interpJumpLow;
          end
          // Character and map modes are consumed here and produce nothing
        end

        interpBlank: begin
          lineCnt <= lineCnt - 1'b1;
          if (lineCnt == lineCntWidth'(1)) begin
            state <= interpDecode;
          end
        end

        interpJumpLow: begin
          if (!empty) begin
            state <= interpJumpHigh;
          end
        end

        interpJumpHigh: begin
          if (!empty) begin
            // Address is complete, pulse the jump next cycle
            dlistJump <= 1'b1;
            dlistEnd  <= jvbFlag;
            state     <= interpJumpExec;
          end
        end

        interpJumpExec: begin
          // Fetcher reloads and the FIFO flushes during this cycle
          state <= jvbFlag ? interpWaitVblank : interpDecode;
        end

        interpWaitVblank: begin
          // End of frame, nothing is taken until the next vertical blank
          if (vblank) begin
            dlistEnd <= 1'b0;
            state    <= interpDecode;
          end
        end

        default: begin
          state <= interpDecode;
        end
      endcase
    end
  end

  // Jump operands and the line code only matter next to their strobes
  always_ff @(posedge Fphi0) begin
    if (jumpStart) begin
      jvbFlag <= popData[`OP_JVB_BIT];
    end
    if ((state == interpJumpLow) && !empty) begin
      jumpAddr[7:0] <= popData;
    end
    if ((state == interpJumpHigh) && !empty) begin
      jumpAddr[15:8] <= popData;
    end
    if (lineSend) begin
      AN <= `AN_BG_COLOR;
    end
  end

endmodule

// ==== logic/anticDisplayList.sv ====
// ############################
// Display list engine top
// ############################

`timescale 1ns/1ps
`include "anticParams.svh"

module anticDisplayList (
  input  logic             Fphi0,
  input  logic             RST,
  input  logic             dlistLoad,
  input  anticPkg::dlAddrT dlistStart,
  input  logic             vblank,
  output anticPkg::dlAddrT memAddr,
  output logic             memRead,
  input  anticPkg::dlByteT memData,
  input  logic             memValid,
  output anticPkg::anCodeT AN,
  output logic             anValid,
  output logic             dlistJump,
  output anticPkg::dlAddrT jumpAddr,
  output logic             dlistEnd
);
  import anticPkg::*;

  // Fetcher to buffer
  logic                                    push;
  dlByteT                                  pushData;
  logic                                    flush;
  logic [$clog2(`DL_FIFO_DEPTH + 1) - 1:0] fifoCount;

  // Buffer to interpreter
  logic   pop;
  dlByteT popData;
  logic   empty;

  dlFetcher fetcher (
    .Fphi0      (Fphi0),
    .RST        (RST),
    .dlistLoad  (dlistLoad),
    .dlistStart (dlistStart),
    .dlistJump  (dlistJump),
    .jumpAddr   (jumpAddr),
    .memAddr    (memAddr),
    .memRead    (memRead),
    .memData    (memData),
    .memValid   (memValid),
    .fifoCount  (fifoCount),
    .push       (push),
    .pushData   (pushData),
    .flush      (flush)
  );

  dlBuffer buffer (
    .Fphi0    (Fphi0),
    .RST      (RST),
    .push     (push),
    .pushData (pushData),
    .pop      (pop),
    .popData  (popData),
    .flush    (flush),
    .empty    (empty),
    .count    (fifoCount)
  );

  // Jump requests loop back to the fetcher and also leave the chip
  dlInterpreter interpreter (
    .Fphi0     (Fphi0),
    .RST       (RST),
    .vblank    (vblank),
    .empty     (empty),
    .popData   (popData),
    .pop       (pop),
    .AN        (AN),
    .anValid   (anValid),
    .dlistJump (dlistJump),
    .jumpAddr  (jumpAddr),
    .dlistEnd  (dlistEnd)
  );

endmodule

// ==== verif/dlRamModel.sv ====
// ############################
// Display list RAM model
// ############################

`timescale 1ns/1ps

module dlRamModel (
  input  logic             Fphi0,
  input  logic             RST,
  input  anticPkg::dlAddrT memAddr,
  input  logic             memRead,
  input  logic [2:0]       memLatency,
  output anticPkg::dlByteT memData,
  output logic             memValid
);
  import anticPkg::*;

  dlByteT     mem [65536];
  dlAddrT     addrHeld;
  logic [2:0] waitCnt;

  // Bytes that no list uses hold a pattern of their whole address
  initial begin
    for (int a = 0; a < 65536; a++) begin
      mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5A;
    end
  end

  // A read seen on one edge is answered memLatency cycles after its strobe
  always_ff @(posedge Fphi0) begin
    if (RST) begin
      memValid <= 1'b0;
      waitCnt  <= '0;
      addrHeld <= '0;
    end else begin
      memValid <= 1'b0;
      if (memRead) begin
        addrHeld <= memAddr;
        if (memLatency <= 3'd1) begin
          memValid <= 1'b1;
          memData  <= mem[memAddr];
        end else begin
          waitCnt <= memLatency - 3'd1;
        end
      end else if (waitCnt != '0) begin
        waitCnt <= waitCnt - 3'd1;
        // Last cycle of the wait puts the byte on the bus
        if (waitCnt == 3'd1) begin
          memValid <= 1'b1;
          memData  <= mem[addrHeld];
        end
      end
    end
  end

endmodule

// ==== verif/tbAnticDisplayList.sv ====
// ############################
// Display list testbench
// ############################

`timescale 1ns/1ps
`include "anticParams.svh"

module tbAnticDisplayList;
  import anticPkg::*;

  localparam int         numFrames  = 6;
  localparam int         loadFrame  = 2;
  localparam logic [5:0] decoyBlock = 6'd63;
  localparam logic [1:0] evLine     = 2'd1;
  localparam logic [1:0] evJump     = 2'd2;
  localparam logic [1:0] evJumpEnd  = 2'd3;

  logic        Fphi0;
  logic        RST;
  logic        dlistLoad;
  logic        vblank;
  logic        memRead;
  logic        memValid;
  logic        anValid;
  logic        dlistJump;
  logic        dlistEnd;
  logic [2:0]  memLatency;
  dlAddrT      dlistStart;
  dlAddrT      memAddr;
  dlAddrT      jumpAddr;
  dlByteT      memData;
  anCodeT      AN;
  logic [15:0] lfsrState = 16'd19;
  logic [31:0] expected [$];
  dlAddrT      frameStart [numFrames];
  dlAddrT      resumeAddr [numFrames];
  int          vblankDelay [numFrames];
  dlAddrT      nextRead;
  logic        waitingVblank;
  int          totalBytes;
  int          eventIdx;
  int          cycles;
  int          cycleLimit;

  anticDisplayList UUT (.*);

  dlRamModel ram (.*);

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken, the new low bit goes in at the bottom
  function automatic int takeBits(input int n);
    int value = 0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrStep(lfsrState);
      value = (value << 1) | int'(lfsrState[0]);
    end
    return value;
  endfunction

  // Pointer step, the upper 6 bits pick the 1 KB block and never change
  function automatic dlAddrT wrapNext(input dlAddrT a);
    return {a[15:10], a[9:0] + 10'd1};
  endfunction

  function automatic logic [31:0] makeEvent(input logic [1:0] kind, input logic [15:0] data);
    return {14'd0, kind, data};
  endfunction

  // Half of the segments start close to the block top so they wrap
  function automatic dlAddrT segmentAddr(input logic [5:0] block);
    logic [9:0] low;
    if (takeBits(1) == 1) begin
      low = 10'h3F8 + 10'(takeBits(3));
    end else begin
      low = 10'(takeBits(10));
    end
    return {block, low};
  endfunction

  task automatic stopWithError(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkValue(input string testName, input logic [31:0] exp,
                            input logic [31:0] act);
    if (exp !== act) begin
      stopWithError($sformatf("Mismatch in %s: expected %0h, actual %0h", testName, exp, act));
    end
  endtask

  task automatic expectEvent(input logic [31:0] actual);
    if (expected.size() == 0) begin
      stopWithError("The DUT sent a line or a jump after the model ran out of events");
    end else begin
      checkValue($sformatf("event %0d", eventIdx), expected.pop_front(), actual);
      eventIdx++;
    end
  endtask

  task automatic putByte(inout dlAddrT ptr, input dlByteT b);
    ram.mem[ptr] = b;
    ptr = wrapNext(ptr);
    totalBytes++;
  endtask

  // Opcode with random DLI and spare bits, then the target low and high bytes
  task automatic putJump(inout dlAddrT ptr, input logic jvb, input dlAddrT target);
    putByte(ptr, {1'(takeBits(1)), jvb, 2'(takeBits(2)), `OP_MODE_JUMP});
    putByte(ptr, target[7:0]);
    putByte(ptr, target[15:8]);
  endtask

  // Every frame sits in its own blocks and ends in a wait for vertical blank
  task automatic buildLists;
    dlAddrT     ptr;
    dlAddrT     target;
    logic [3:0] mode;
    int         segs;
    int         nextBlock;
    nextBlock  = numFrames + 1;
    totalBytes = 0;
    for (int f = 0; f < numFrames; f++) begin
      frameStart[f] = segmentAddr(6'(f + 1));
    end
    for (int f = 0; f < numFrames; f++) begin
      ptr  = frameStart[f];
      segs = 1 + takeBits(1);
      for (int s = 0; s < segs; s++) begin
        repeat (2 + takeBits(2)) begin
          if (takeBits(1) == 0) begin
            putByte(ptr, {1'(takeBits(1)), 3'(takeBits(3)), `OP_MODE_BLANK});
          end else begin
            // Character or map mode, only its opcode byte is stored
            mode = 4'(takeBits(4));
            if (mode < 4'd2) begin
              mode = mode + 4'd2;
            end
            putByte(ptr, {4'(takeBits(4)), mode});
          end
        end
        if (s < segs - 1) begin
          target = segmentAddr(6'(nextBlock));
          nextBlock++;
          putJump(ptr, 1'b0, target);
          ptr = target;
        end
      end
      // The load frame and the last frame jump into a block no list uses
      if ((f == loadFrame) || (f == numFrames - 1)) begin
        target = segmentAddr(decoyBlock);
      end else begin
        target = frameStart[f + 1];
      end
      putJump(ptr, 1'b1, target);
      resumeAddr[f]  = (f == numFrames - 1) ? target : frameStart[f + 1];
      vblankDelay[f] = takeBits(4);
    end
    cycleLimit = 40 * totalBytes + 200;
  endtask

  // Walks the RAM image by the instruction rules and queues the output events
  task automatic walkModel;
    dlAddrT ptr;
    dlAddrT target;
    dlByteT op;
    int     frame;
    ptr   = frameStart[0];
    frame = 0;
    while (frame < numFrames) begin
      op  = ram.mem[ptr];
      ptr = wrapNext(ptr);
      if (op[`OP_MODE_MSB:`OP_MODE_LSB] == `OP_MODE_BLANK) begin
        repeat (int'(op[`OP_COUNT_MSB:`OP_COUNT_LSB]) + 1) begin
          expected.push_back(makeEvent(evLine, 16'(`AN_BG_COLOR)));
        end
      end else if (op[`OP_MODE_MSB:`OP_MODE_LSB] == `OP_MODE_JUMP) begin
        target[7:0]  = ram.mem[ptr];
        ptr          = wrapNext(ptr);
        target[15:8] = ram.mem[ptr];
        ptr          = wrapNext(ptr);
        if (op[`OP_JVB_BIT]) begin
          // After vblank the walk goes on where the next frame really starts
          expected.push_back(makeEvent(evJumpEnd, target));
          ptr = resumeAddr[frame];
          frame++;
        end else begin
          expected.push_back(makeEvent(evJump, target));
          ptr = target;
        end
      end
    end
  endtask

  initial begin
    Fphi0 = 1'b0;
    forever #2 Fphi0 = ~Fphi0;
  end

  // New reply latency of 1 to 4 cycles just after every edge
  always @(posedge Fphi0) begin
    #1;
    memLatency = 3'(takeBits(2)) + 3'd1;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge Fphi0);
      cycles++;
      if (cycles > cycleLimit) begin
        stopWithError($sformatf("Timeout, the run did not end within %0d cycles", cycleLimit));
      end
    end
  end

  // Outputs are stable at the falling edge
  // A read is checked before a reload in the same cycle, since it used the old pointer
  always @(negedge Fphi0) begin
    if (!RST) begin
      if (memRead) begin
        checkValue("read address", nextRead, memAddr);
        nextRead = wrapNext(memAddr);
      end
      if (dlistLoad) begin
        nextRead = dlistStart;
      end
      if (anValid) begin
        if (waitingVblank) begin
          stopWithError("The DUT sent a line while the list waited for vertical blank");
        end
        expectEvent(makeEvent(evLine, 16'(AN)));
      end
      if (dlistJump) begin
        nextRead = jumpAddr;
        // The model says whether this jump ends the list until the next vblank
        if (expected.size() != 0) begin
          waitingVblank = (expected[0][17:16] == evJumpEnd);
        end
        expectEvent(makeEvent(dlistEnd ? evJumpEnd : evJump, jumpAddr));
      end
    end
  end

  initial begin
    RST           = 1'b1;
    dlistLoad     = 1'b0;
    dlistStart    = '0;
    vblank        = 1'b0;
    memLatency    = 3'd1;
    nextRead      = '0;
    waitingVblank = 1'b0;
    eventIdx      = 0;
    cycleLimit    = 1000;
    #1;
    buildLists();
    walkModel();
    repeat (3) @(posedge Fphi0);
    #1;
    // CPU points the chip at the first frame as reset ends
    RST        = 1'b0;
    dlistLoad  = 1'b1;
    dlistStart = frameStart[0];
    @(posedge Fphi0);
    #1;
    dlistLoad = 1'b0;
    for (int f = 0; f < numFrames - 1; f++) begin
      wait (dlistEnd === 1'b1);
      repeat (vblankDelay[f] + 1) @(posedge Fphi0);
      if (f == loadFrame) begin
        // Mid-run CPU load while the interpreter idles at the end of the list
        #1;
        dlistLoad  = 1'b1;
        dlistStart = frameStart[f + 1];
        @(posedge Fphi0);
        #1;
        dlistLoad = 1'b0;
        repeat (2) @(posedge Fphi0);
      end
      #1;
      // The end level must last for the whole wait
      checkValue($sformatf("end held until vblank %0d", f), 1, dlistEnd);
      waitingVblank = 1'b0;
      vblank        = 1'b1;
      @(posedge Fphi0);
      #1;
      vblank = 1'b0;
      @(negedge Fphi0);
      checkValue($sformatf("end cleared by vblank %0d", f), 0, dlistEnd);
    end
    wait (dlistEnd === 1'b1);
    repeat (4) @(negedge Fphi0);
    checkValue("events left at the end", 0, expected.size());
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/anticPkg.sv
logic/dlFetcher.sv
logic/dlBuffer.sv
logic/dlInterpreter.sv
logic/anticDisplayList.sv
verif/dlRamModel.sv
verif/tbAnticDisplayList.sv

// ==== Bender.yml ====
package:
  name: antic_display_list

sources:
  - include_dirs:
      - logic
    files:
      - logic/anticPkg.sv
      - logic/dlFetcher.sv
      - logic/dlBuffer.sv
      - logic/dlInterpreter.sv
      - logic/anticDisplayList.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/dlRamModel.sv
      - verif/tbAnticDisplayList.sv
